// File: common/mz_pkg.sv
`default_nettype none

package mz_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [10:0] vaddr_t;
	typedef logic [15:0] count_t;
	typedef logic [3:0]  key_row_t;
	typedef logic [2:0]  key_col_t;

	// Memory map
	localparam addr_t VRAM_BASE     = 16'hD000;
	localparam int    VRAM_BYTES    = 2048;
	localparam addr_t KEY_ROW_ADDR  = 16'hE000;
	localparam addr_t KEY_DATA_ADDR = 16'hE001;
	localparam addr_t PIT_BASE      = 16'hE004;
	localparam addr_t SPEAKER_ADDR  = 16'hE008;
	localparam addr_t MAIN_RAM_TOP  = 16'h8FFF;

	localparam int KEY_ROWS = 10;

	// Mode 2 and mode 3 of the 8253
	typedef enum logic {
		rate,
		square
	} pit_mode_e;

	typedef enum logic [1:0] {
		idle,
		loaded,
		counting
	} pit_state_e;

endpackage

`default_nettype wire

// File: hdl/clock_divider.sv
`timescale 1ns/10ps
`default_nettype none

module clock_divider #(
	parameter int TICK_2M_DIV  = 25,
	parameter int TICK_31K_DIV = 1600
) (
	input  wire CLK_50MHZ,
	input  wire RESET,
	output wire tick_2m,
	output wire tick_31k
);

	logic [1:0] ticks;

	// One wrapping counter per enable that ticks on its last count
	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int DIV = (i == 0) ? TICK_2M_DIV : TICK_31K_DIV;
		localparam int CW  = $clog2(DIV);

		logic [CW-1:0] cnt;

		always_ff @(posedge CLK_50MHZ or posedge RESET) begin
			if (RESET) begin
				cnt <= '0;
			end else if (cnt == CW'(DIV - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end

		assign ticks[i] = (cnt == CW'(DIV - 1));
	end

	assign tick_2m  = ticks[0];
	assign tick_31k = ticks[1];

endmodule

`default_nettype wire

// File: pit8253/pit_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pit_counter (
	input  wire               CLK_50MHZ,
	input  wire               RESET,
	input  wire               tick,
	input  mz_pkg::pit_mode_e mode,
	input  wire               ctrl_wr,
	input  wire               data_wr,
	input  wire               data_rd,
	input  mz_pkg::byte_t     wdata,
	output mz_pkg::byte_t     rdata,
	output logic              out_level
);

	mz_pkg::pit_state_e state;
	mz_pkg::pit_mode_e  mode_q;
	mz_pkg::count_t     reload;
	mz_pkg::count_t     count;
	mz_pkg::count_t     step;
	mz_pkg::byte_t      lsb_q;
	logic               wr_msb;
	logic               rd_msb;
	logic               at_end;

	// Square wave steps by two, so 2 (or 1 for odd counts) ends a half period
	assign step   = (mode_q == mz_pkg::square) ? 16'd2 : 16'd1;
	assign at_end = (mode_q == mz_pkg::square) ? (count == 16'd2 || count == 16'd1)
		: (count == 16'd1);

	always_ff @(posedge CLK_50MHZ or posedge RESET) begin
		if (RESET) begin
			state     <= mz_pkg::idle;
			mode_q    <= mz_pkg::rate;
			wr_msb    <= 1'b0;
			rd_msb    <= 1'b0;
			out_level <= 1'b1;
		end else if (ctrl_wr) begin
			state     <= mz_pkg::idle;
			mode_q    <= mode;
			wr_msb    <= 1'b0;
			rd_msb    <= 1'b0;
			out_level <= 1'b1;
		end else begin
			if (tick) begin
				case (state)
					mz_pkg::loaded: begin
						state     <= mz_pkg::counting;
						out_level <= 1'b1;
					end
					mz_pkg::counting: begin
						if (at_end)
							out_level <= (mode_q == mz_pkg::square) ? ~out_level : 1'b1;
						else if (mode_q == mz_pkg::rate)
							out_level <= (count != 16'd2);
					end
					default: ;
				endcase
			end
			// A new MSB restarts the count even mid-period
			if (data_wr) begin
				wr_msb <= ~wr_msb;
				if (wr_msb)
					state <= mz_pkg::loaded;
			end
			if (data_rd)
				rd_msb <= ~rd_msb;
		end
	end

	always_ff @(posedge CLK_50MHZ) begin
		if (data_wr && !wr_msb)
			lsb_q <= wdata;
		if (data_wr && wr_msb)
			reload <= {wdata, lsb_q};
		if (data_rd)
			rdata <= rd_msb ? count[15:8] : count[7:0];
		if (tick) begin
			if (state == mz_pkg::loaded || (state == mz_pkg::counting && at_end))
				count <= reload;
			else if (state == mz_pkg::counting)
				count <= count - step;
		end
	end

endmodule

`default_nettype wire

// File: pit8253/pit8253.sv
`timescale 1ns/10ps
`default_nettype none

module pit8253 (
	input  wire           CLK_50MHZ,
	input  wire           RESET,
	input  wire           tick0,
	input  wire           tick1,
	input  wire [1:0]     sel,
	input  wire           wr,
	input  wire           rd,
	input  mz_pkg::byte_t wdata,
	output mz_pkg::byte_t rdata,
	output wire           out0,
	output wire           out1,
	output wire           out2
);

	logic [2:0]        tick;
	logic [2:0]        out;
	logic [2:0]        ctrl_wr;
	logic [2:0]        data_wr;
	logic [2:0]        data_rd;
	mz_pkg::byte_t     cnt_rdata [3];
	mz_pkg::pit_mode_e ctrl_mode;
	logic              out1_q;
	logic [1:0]        rd_sel_q;

	// Bit 1 of the mode field separates mode 3 from mode 2
	assign ctrl_mode = wdata[1] ? mz_pkg::square : mz_pkg::rate;

	// Counter 2 is clocked by the rising edge of out1
	assign tick[0] = tick0;
	assign tick[1] = tick1;
	assign tick[2] = out[1] & ~out1_q;

	always_ff @(posedge CLK_50MHZ or posedge RESET) begin
		if (RESET) begin
			out1_q   <= 1'b1;
			rd_sel_q <= 2'd0;
		end else begin
			out1_q <= out[1];
			if (rd)
				rd_sel_q <= sel;
		end
	end

	for (genvar i = 0; i < 3; i++) begin : g_cnt
		assign ctrl_wr[i] = wr && (sel == 2'd3) && (wdata[7:6] == 2'(i));
		assign data_wr[i] = wr && (sel == 2'(i));
		assign data_rd[i] = rd && (sel == 2'(i));

		pit_counter u_counter (
			.CLK_50MHZ (CLK_50MHZ),
			.RESET     (RESET),
			.tick      (tick[i]),
			.mode      (ctrl_mode),
			.ctrl_wr   (ctrl_wr[i]),
			.data_wr   (data_wr[i]),
			.data_rd   (data_rd[i]),
			.wdata     (wdata),
			.rdata     (cnt_rdata[i]),
			.out_level (out[i])
		);
	end

	// No read-back of the control port
	assign rdata = (rd_sel_q == 2'd3) ? 8'hFF : cnt_rdata[rd_sel_q];

	assign out0 = out[0];
	assign out1 = out[1];
	assign out2 = out[2];

endmodule

`default_nettype wire

// File: hdl/key_matrix.sv
`timescale 1ns/10ps
`default_nettype none

module key_matrix (
	input  wire              CLK_50MHZ,
	input  wire              RESET,
	input  wire              key_stb,
	input  mz_pkg::key_row_t key_row,
	input  mz_pkg::key_col_t key_col,
	input  wire              key_down,
	input  mz_pkg::key_row_t row_sel,
	output mz_pkg::byte_t    row_data
);

	mz_pkg::byte_t rows [mz_pkg::KEY_ROWS];
	logic          row_ok;
	logic          sel_ok;

	assign row_ok = (int'(key_row) < mz_pkg::KEY_ROWS);
	assign sel_ok = (int'(row_sel) < mz_pkg::KEY_ROWS);

	// Keys are active low so a pressed key reads 0
	always_ff @(posedge CLK_50MHZ or posedge RESET) begin
		if (RESET) begin
			for (int r = 0; r < mz_pkg::KEY_ROWS; r++)
				rows[r] <= 8'hFF;
		end else if (key_stb && row_ok) begin
			rows[key_row][key_col] <= ~key_down;
		end
	end

	assign row_data = sel_ok ? rows[row_sel] : 8'hFF;

endmodule

`default_nettype wire

// File: hdl/video_ram.sv
`timescale 1ns/10ps
`default_nettype none

module video_ram (
	input  wire            CLK_50MHZ,
	input  wire            cpu_we,
	input  mz_pkg::vaddr_t cpu_addr,
	input  mz_pkg::byte_t  cpu_wdata,
	input  mz_pkg::vaddr_t vid_addr,
	output mz_pkg::byte_t  cpu_rdata,
	output mz_pkg::byte_t  vid_data
);

	localparam int DEPTH = 2 ** $bits(mz_pkg::vaddr_t);

	mz_pkg::byte_t mem [DEPTH];

	// CPU port returns the old byte when it writes
	always_ff @(posedge CLK_50MHZ) begin
		if (cpu_we)
			mem[cpu_addr] <= cpu_wdata;
		cpu_rdata <= mem[cpu_addr];
	end

	// Scan-out port only reads
	always_ff @(posedge CLK_50MHZ) begin
		vid_data <= mem[vid_addr];
	end

endmodule

`default_nettype wire

// File: hdl/memory_map.sv
`timescale 1ns/10ps
`default_nettype none

module memory_map #(
	parameter int MAIN_RAM_BYTES = 36864
) (
	input  wire              CLK_50MHZ,
	input  wire              RESET,
	input  mz_pkg::addr_t    bus_addr,
	input  mz_pkg::byte_t    bus_wdata,
	input  wire              bus_rd,
	input  wire              bus_wr,
	input  mz_pkg::byte_t    vram_rdata,
	input  mz_pkg::byte_t    row_data,
	input  mz_pkg::byte_t    pit_rdata,
	output mz_pkg::byte_t    rd_data,
	output logic             rd_valid,
	output wire              vram_we,
	output wire              pit_rd,
	output wire              pit_wr,
	output mz_pkg::key_row_t row_sel,
	output logic             speaker_en
);

	localparam int RAM_AW = $clog2(MAIN_RAM_BYTES);

	// Read source codes
	localparam logic [2:0] SRC_NONE = 3'd0;
	localparam logic [2:0] SRC_RAM  = 3'd1;
	localparam logic [2:0] SRC_VRAM = 3'd2;
	localparam logic [2:0] SRC_KEY  = 3'd3;
	localparam logic [2:0] SRC_PIT  = 3'd4;

	mz_pkg::byte_t     ram [MAIN_RAM_BYTES];
	mz_pkg::byte_t     ram_q;
	mz_pkg::byte_t     key_q;
	logic [RAM_AW-1:0] ram_idx;
	logic [2:0]        src;
	logic [2:0]        src_q;
	logic              ram_hit;
	logic              vram_hit;
	logic              pit_hit;

	assign ram_hit  = (bus_addr <= mz_pkg::MAIN_RAM_TOP) && (int'(bus_addr) < MAIN_RAM_BYTES);
	assign vram_hit = (bus_addr >= mz_pkg::VRAM_BASE)
		&& (int'(bus_addr) < int'(mz_pkg::VRAM_BASE) + mz_pkg::VRAM_BYTES);
	assign pit_hit  = (bus_addr[15:2] == mz_pkg::PIT_BASE[15:2]);
	assign ram_idx  = RAM_AW'(bus_addr);

	assign vram_we = bus_wr && vram_hit;
	assign pit_rd  = bus_rd && pit_hit;
	assign pit_wr  = bus_wr && pit_hit;

	always_comb begin
		if (ram_hit)
			src = SRC_RAM;
		else if (vram_hit)
			src = SRC_VRAM;
		else if (bus_addr == mz_pkg::KEY_DATA_ADDR)
			src = SRC_KEY;
		else if (pit_hit)
			src = SRC_PIT;
		else
			src = SRC_NONE;
	end

	always_ff @(posedge CLK_50MHZ) begin
		if (bus_wr && ram_hit)
			ram[ram_idx] <= bus_wdata;
		if (bus_rd && ram_hit)
			ram_q <= ram[ram_idx];
		if (bus_rd)
			key_q <= row_data;
	end

	always_ff @(posedge CLK_50MHZ or posedge RESET) begin
		if (RESET) begin
			rd_valid   <= 1'b0;
			src_q      <= SRC_NONE;
			row_sel    <= '0;
			speaker_en <= 1'b0;
		end else begin
			rd_valid <= bus_rd;
			if (bus_rd)
				src_q <= src;
			if (bus_wr && bus_addr == mz_pkg::KEY_ROW_ADDR)
				row_sel <= bus_wdata[3:0];
			if (bus_wr && bus_addr == mz_pkg::SPEAKER_ADDR)
				speaker_en <= bus_wdata[0];
		end
	end

	// Every source is already one cycle behind the strobe
	always_comb begin
		case (src_q)
			SRC_RAM:  rd_data = ram_q;
			SRC_VRAM: rd_data = vram_rdata;
			SRC_KEY:  rd_data = key_q;
			SRC_PIT:  rd_data = pit_rdata;
			default:  rd_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/mz80k_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module mz80k_io_top #(
	parameter int TICK_2M_DIV    = 25,
	parameter int TICK_31K_DIV   = 1600,
	parameter int MAIN_RAM_BYTES = 36864
) (
	input  wire              CLK_50MHZ,
	input  wire              RESET,
	input  mz_pkg::addr_t    bus_addr,
	input  mz_pkg::byte_t    bus_wdata,
	input  wire              bus_rd,
	input  wire              bus_wr,
	input  wire              key_stb,
	input  mz_pkg::key_row_t key_row,
	input  mz_pkg::key_col_t key_col,
	input  wire              key_down,
	input  mz_pkg::vaddr_t   vid_addr,
	output mz_pkg::byte_t    rd_data,
	output wire              rd_valid,
	output mz_pkg::byte_t    vid_data,
	output wire              speaker,
	output wire              timer_irq
);

	wire              tick_2m;
	wire              tick_31k;
	wire              vram_we;
	wire              pit_rd;
	wire              pit_wr;
	wire              speaker_en;
	wire              out0;
	wire              out1;
	wire              out2;
	mz_pkg::byte_t    vram_rdata;
	mz_pkg::byte_t    row_data;
	mz_pkg::byte_t    pit_rdata;
	mz_pkg::key_row_t row_sel;

	clock_divider #(
		.TICK_2M_DIV  (TICK_2M_DIV),
		.TICK_31K_DIV (TICK_31K_DIV)
	) u_clock_divider (
		.CLK_50MHZ (CLK_50MHZ),
		.RESET     (RESET),
		.tick_2m   (tick_2m),
		.tick_31k  (tick_31k)
	);

	// Counter 0 at 2 MHz, counter 1 at 31.25 kHz
	pit8253 u_pit8253 (
		.CLK_50MHZ (CLK_50MHZ), .RESET (RESET),
		.tick0 (tick_2m), .tick1 (tick_31k), .sel (bus_addr[1:0]),
		.wr (pit_wr), .rd (pit_rd), .wdata (bus_wdata), .rdata (pit_rdata),
		.out0 (out0), .out1 (out1), .out2 (out2)
	);

	key_matrix u_key_matrix (
		.CLK_50MHZ (CLK_50MHZ), .RESET (RESET),
		.key_stb (key_stb), .key_row (key_row), .key_col (key_col),
		.key_down (key_down), .row_sel (row_sel), .row_data (row_data)
	);

	video_ram u_video_ram (
		.CLK_50MHZ (CLK_50MHZ), .cpu_we (vram_we),
		.cpu_addr (bus_addr[10:0]), .cpu_wdata (bus_wdata),
		.vid_addr (vid_addr), .cpu_rdata (vram_rdata), .vid_data (vid_data)
	);

	memory_map #(
		.MAIN_RAM_BYTES (MAIN_RAM_BYTES)
	) u_memory_map (
		.CLK_50MHZ (CLK_50MHZ), .RESET (RESET),
		.bus_addr (bus_addr), .bus_wdata (bus_wdata),
		.bus_rd (bus_rd), .bus_wr (bus_wr),
		.vram_rdata (vram_rdata), .row_data (row_data), .pit_rdata (pit_rdata),
		.rd_data (rd_data), .rd_valid (rd_valid), .vram_we (vram_we),
		.pit_rd (pit_rd), .pit_wr (pit_wr),
		.row_sel (row_sel), .speaker_en (speaker_en)
	);

	assign speaker   = speaker_en & out0;
	assign timer_irq = out2;

endmodule

`default_nettype wire

// File: bench/mz80k_io_props.sv
`timescale 1ns/10ps
`default_nettype none

module mz80k_io_props (
	input wire CLK_50MHZ,
	input wire RESET,
	input wire bus_rd,
	input wire bus_wr,
	input wire rd_valid,
	input wire speaker,
	input wire speaker_en
);

	int unsigned rd_fails = 0;
	int unsigned strobe_fails = 0;
	int unsigned speaker_fails = 0;
	int unsigned fail_count;

	assign fail_count = rd_fails + strobe_fails + speaker_fails;

	// rd_valid comes exactly one cycle after each read strobe
	a_rd_valid: assert property (@(posedge CLK_50MHZ) disable iff (RESET)
		bus_rd |=> rd_valid)
		else begin
			$error("rd_valid missing one cycle after bus_rd");
			rd_fails++;
		end

	a_rd_only: assert property (@(posedge CLK_50MHZ) disable iff (RESET)
		!bus_rd |=> !rd_valid)
		else begin
			$error("rd_valid high without a bus_rd the cycle before");
			rd_fails++;
		end

	a_strobes: assert property (@(posedge CLK_50MHZ) disable iff (RESET)
		!(bus_rd && bus_wr))
		else begin
			$error("bus_rd and bus_wr high together");
			strobe_fails++;
		end

	a_speaker: assert property (@(posedge CLK_50MHZ) disable iff (RESET)
		!speaker_en |-> !speaker)
		else begin
			$error("speaker high while its enable is low");
			speaker_fails++;
		end

endmodule

bind mz80k_io_top mz80k_io_props u_props (
	.CLK_50MHZ  (CLK_50MHZ),
	.RESET      (RESET),
	.bus_rd     (bus_rd),
	.bus_wr     (bus_wr),
	.rd_valid   (rd_valid),
	.speaker    (speaker),
	.speaker_en (speaker_en)
);

`default_nettype wire

// File: bench/tb_mz80k_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mz80k_io;

	localparam int TICK_2M_DIV    = 25;
	localparam int TICK_31K_DIV   = 1600;
	localparam int MAIN_RAM_BYTES = 36864;
	// Cascade test dominates at about 31k cycles
	localparam int CYCLE_LIMIT    = 60000;
	localparam int WAIT_LIMIT     = 20000;

	logic             CLK_50MHZ;
	logic             RESET;
	mz_pkg::addr_t    bus_addr;
	mz_pkg::byte_t    bus_wdata;
	logic             bus_rd;
	logic             bus_wr;
	logic             key_stb;
	mz_pkg::key_row_t key_row;
	mz_pkg::key_col_t key_col;
	logic             key_down;
	mz_pkg::vaddr_t   vid_addr;
	mz_pkg::byte_t    rd_data;
	logic             rd_valid;
	mz_pkg::byte_t    vid_data;
	logic             speaker;
	logic             timer_irq;

	int            cycle = 0;
	logic [31:0]   rng = 32'd24035;
	mz_pkg::byte_t key_model [16];

	mz80k_io_top #(
		.TICK_2M_DIV    (TICK_2M_DIV),
		.TICK_31K_DIV   (TICK_31K_DIV),
		.MAIN_RAM_BYTES (MAIN_RAM_BYTES)
	) DUT (
		.CLK_50MHZ (CLK_50MHZ), .RESET (RESET),
		.bus_addr (bus_addr), .bus_wdata (bus_wdata), .bus_rd (bus_rd), .bus_wr (bus_wr),
		.key_stb (key_stb), .key_row (key_row), .key_col (key_col), .key_down (key_down),
		.vid_addr (vid_addr), .rd_data (rd_data), .rd_valid (rd_valid),
		.vid_data (vid_data), .speaker (speaker), .timer_irq (timer_irq)
	);

	initial begin
		CLK_50MHZ = 1'b0;
		forever #10 CLK_50MHZ = ~CLK_50MHZ;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("Fail %s: got %0h expected %0h", name, got, exp));
	endtask

	always @(posedge CLK_50MHZ) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
			stop_run("Timeout, the run went past its cycle limit");
		if (DUT.u_props.fail_count != 0)
			stop_run("A bus or speaker assertion fired");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic bus_write(input mz_pkg::addr_t addr, input mz_pkg::byte_t data);
		bus_addr  = addr;
		bus_wdata = data;
		bus_wr    = 1'b1;
		@(posedge CLK_50MHZ);
		#2;
		bus_wr = 1'b0;
	endtask

	task automatic bus_read(input mz_pkg::addr_t addr, output mz_pkg::byte_t data);
		int waited;
		waited   = 0;
		bus_addr = addr;
		bus_rd   = 1'b1;
		@(posedge CLK_50MHZ);
		#2;
		bus_rd = 1'b0;
		while (!rd_valid) begin
			if (waited == 8)
				stop_run("No rd_valid after a bus read");
			waited++;
			@(posedge CLK_50MHZ);
			#2;
		end
		data = rd_data;
	endtask

	task automatic key_event(input int row, input int col, input logic down);
		key_row  = 4'(row);
		key_col  = 3'(col);
		key_down = down;
		key_stb  = 1'b1;
		@(posedge CLK_50MHZ);
		#2;
		key_stb = 1'b0;
	endtask

	// Waits until speaker (or timer_irq) is at the level
	task automatic wait_level(input logic use_irq, input logic level);
		int n;
		n = 0;
		while ((use_irq ? timer_irq : speaker) != level) begin
			if (n == WAIT_LIMIT)
				stop_run("Timer output stopped toggling");
			n++;
			@(posedge CLK_50MHZ);
			#2;
		end
	endtask

	task automatic ram_readback();
		mz_pkg::addr_t addrs [40];
		mz_pkg::byte_t datas [40];
		mz_pkg::byte_t got;
		logic          dup;
		for (int i = 0; i < 40; i++) begin
			do begin
				rng = xorshift(rng);
				if (rng[31])
					addrs[i] = rng[15:0] % 16'h9000;
				else
					addrs[i] = mz_pkg::VRAM_BASE + {5'b0, rng[10:0]};
				dup = 1'b0;
				for (int j = 0; j < i; j++)
					if (addrs[j] == addrs[i])
						dup = 1'b1;
			end while (dup);
			datas[i] = rng[23:16];
			bus_write(addrs[i], datas[i]);
		end
		for (int i = 0; i < 40; i++) begin
			bus_read(addrs[i], got);
			check($sformatf("rd_data at %h", addrs[i]), int'(got), int'(datas[i]));
		end
		bus_read(16'hA000, got);
		check("rd_data at a000", int'(got), 'hFF);
	endtask

	task automatic video_scanout();
		mz_pkg::vaddr_t k;
		mz_pkg::byte_t  data;
		for (int i = 0; i < 8; i++) begin
			rng  = xorshift(rng);
			k    = rng[10:0];
			data = rng[31:24];
			bus_write(mz_pkg::VRAM_BASE + {5'b0, k}, data);
			vid_addr = k;
			@(posedge CLK_50MHZ);
			#2;
			check($sformatf("vid_data at %h", k), int'(vid_data), int'(data));
		end
	endtask

	task automatic read_key_row(input int row);
		mz_pkg::byte_t got;
		bus_write(mz_pkg::KEY_ROW_ADDR, 8'(row));
		bus_read(mz_pkg::KEY_DATA_ADDR, got);
		check($sformatf("rd_data key row %0d", row), int'(got), int'(key_model[row]));
	endtask

	task automatic key_and_read(input int row, input int col, input logic down);
		key_event(row, col, down);
		// Rows past 9 stay all ones
		if (row < mz_pkg::KEY_ROWS)
			key_model[row][col] = ~down;
		read_key_row(row);
	endtask

	task automatic keyboard_rows();
		key_and_read(3, 5, 1'b1);
		key_and_read(3, 0, 1'b1);
		key_and_read(9, 7, 1'b1);
		key_and_read(0, 2, 1'b1);
		key_and_read(3, 5, 1'b0);
		key_and_read(9, 7, 1'b0);
		key_and_read(12, 1, 1'b1);
		for (int r = 0; r < mz_pkg::KEY_ROWS; r++)
			read_key_row(r);
	endtask

	task automatic speaker_square_wave();
		int t0;
		bus_write(16'hE007, 8'h36);
		bus_write(16'hE004, 8'd4);
		bus_write(16'hE004, 8'd0);
		bus_write(mz_pkg::SPEAKER_ADDR, 8'h01);
		// First high time after loading is longer, so start on a rising edge
		wait_level(1'b0, 1'b0);
		wait_level(1'b0, 1'b1);
		for (int i = 0; i < 3; i++) begin
			t0 = cycle;
			wait_level(1'b0, 1'b0);
			check("speaker high time", cycle - t0, 2 * TICK_2M_DIV);
			t0 = cycle;
			wait_level(1'b0, 1'b1);
			check("speaker low time", cycle - t0, 2 * TICK_2M_DIV);
		end
		bus_write(mz_pkg::SPEAKER_ADDR, 8'h00);
		for (int i = 0; i < 8 * TICK_2M_DIV; i++) begin
			check("speaker", int'(speaker), 0);
			@(posedge CLK_50MHZ);
			#2;
		end
	endtask

	task automatic irq_cascade();
		int            t0;
		mz_pkg::byte_t lsb;
		mz_pkg::byte_t msb;
		bus_write(16'hE007, 8'hB4);
		bus_write(16'hE006, 8'd3);
		bus_write(16'hE006, 8'd0);
		bus_write(16'hE007, 8'h76);
		bus_write(16'hE005, 8'd2);
		bus_write(16'hE005, 8'd0);
		wait_level(1'b1, 1'b0);
		for (int i = 0; i < 2; i++) begin
			t0 = cycle;
			wait_level(1'b1, 1'b1);
			wait_level(1'b1, 1'b0);
			check("timer_irq period", cycle - t0, 3 * 2 * TICK_31K_DIV);
		end
		bus_read(16'hE006, lsb);
		bus_read(16'hE006, msb);
		check("rd_data counter 2 msb", int'(msb), 0);
		if (lsb < 8'd1 || lsb > 8'd3)
			stop_run($sformatf("Fail rd_data counter 2 lsb: got %0h expected 1 to 3", lsb));
	endtask

	initial begin
		RESET     = 1'b1;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_rd    = 1'b0;
		bus_wr    = 1'b0;
		key_stb   = 1'b0;
		key_row   = '0;
		key_col   = '0;
		key_down  = 1'b0;
		vid_addr  = '0;
		for (int r = 0; r < 16; r++)
			key_model[r] = 8'hFF;
		repeat (5) @(posedge CLK_50MHZ);
		#2;
		RESET = 1'b0;
		ram_readback();
		video_scanout();
		keyboard_rows();
		speaker_square_wave();
		irq_cascade();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: mz80k_io_top.f
common/mz_pkg.sv
hdl/clock_divider.sv
pit8253/pit_counter.sv
pit8253/pit8253.sv
hdl/key_matrix.sv
hdl/video_ram.sv
hdl/memory_map.sv
hdl/mz80k_io_top.sv
bench/mz80k_io_props.sv
bench/tb_mz80k_io.sv

// File: Makefile
TOP := tb_mz80k_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f mz80k_io_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f mz80k_io_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
